// File: design/cache_way.sv
`default_nettype none

module cache_way #(
    parameter int WAYS   = 4,
    parameter int WAY_ID = 0
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    cache_way_if.way                   ways_i,
    output logic                       way_hit_o,
    output load_cache_pkg::data_word_t way_data_o
);

    logic [WAYS-1:0] own_bit;
    logic            fill_wr;

    // Line storage, only the valid bits are cleared
    logic [load_cache_pkg::SETS-1:0] valid_r;
    logic [load_cache_pkg::TAG_W-1:0] tag_mem [load_cache_pkg::SETS];
    load_cache_pkg::data_word_t data_mem [load_cache_pkg::SETS][load_cache_pkg::BLOCK_WORDS];

    // Registered view of the set read on the last lookup
    logic                             look_q;
    logic                             valid_q;
    logic [load_cache_pkg::TAG_W-1:0] tag_q;
    load_cache_pkg::data_word_t       rd_data_q;

    // This way only writes when the victim mask names it
    assign own_bit = WAYS'(1) << WAY_ID;
    assign fill_wr = ways_i.fill_we && |(ways_i.fill_mask & own_bit);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_r <= '0;
        end else if (fill_wr && ways_i.fill_last) begin
            valid_r[ways_i.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fill_wr) begin
            data_mem[ways_i.index][ways_i.offset] <= ways_i.fill_data;
        end
        // The tag goes in with the last word, together with the valid bit
        if (fill_wr && ways_i.fill_last) begin
            tag_mem[ways_i.index] <= ways_i.fill_tag;
        end
    end

    // Lookup pipeline
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            look_q <= 1'b0;
        end else begin
            look_q <= ways_i.lookup;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ways_i.lookup) begin
            valid_q   <= valid_r[ways_i.index];
            tag_q     <= tag_mem[ways_i.index];
            rd_data_q <= data_mem[ways_i.index][ways_i.offset];
        end
    end

    // Hit is reported only in the cycle right after a lookup
    assign way_hit_o  = look_q && valid_q && (tag_q == ways_i.fill_tag);
    assign way_data_o = rd_data_q;

    // The controller must never refill two ways at once
    a_fill_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ways_i.fill_we |-> $onehot(ways_i.fill_mask));

endmodule

`default_nettype wire

// File: design/cache_way_if.sv
`default_nettype none

// Lookup and refill commands, broadcast from the controller to every way
interface cache_way_if #(
    parameter int WAYS = 4
) ();

    // One-cycle strobe, each way reads the addressed set on the next edge
    logic lookup;

    // Set and word select, shared by lookups and refill writes
    logic [load_cache_pkg::INDEX_W-1:0]  index;
    logic [load_cache_pkg::OFFSET_W-1:0] offset;

    // One-hot victim, only the selected way accepts refill writes
    logic [WAYS-1:0] fill_mask;

    // Word write strobe during a refill
    logic fill_we;
    load_cache_pkg::data_word_t fill_data;

    // Tag of the current load
    // It is written on the last refill word and also serves as the compare tag
    logic [load_cache_pkg::TAG_W-1:0] fill_tag;

    // Final word of the block, this one also validates the line
    logic fill_last;

    modport ctrl (
        output lookup, index, offset, fill_mask,
        output fill_we, fill_data, fill_tag, fill_last
    );

    modport way (
        input lookup, index, offset, fill_mask,
        input fill_we, fill_data, fill_tag, fill_last
    );

endinterface

`default_nettype wire

// File: design/load_cache_ctrl.sv
`default_nettype none

module load_cache_ctrl #(
    parameter int WAYS = 4
) (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    // Load side
    input  wire logic                        ld_req_i,
    input  wire load_cache_pkg::load_addr_u  ld_addr_i,
    input  wire logic                        ld_cachable_i,
    output load_cache_pkg::data_word_t       ld_data_o,
    output logic                             ld_valid_o,
    output logic                             idle_o,
    // Store side forwarding
    input  wire logic                        fwd_match_i,
    input  wire load_cache_pkg::data_word_t  fwd_data_i,
    // External memory
    output logic                             mem_req_o,
    output load_cache_pkg::data_word_t       mem_addr_o,
    input  wire load_cache_pkg::data_word_t  mem_data_i,
    input  wire logic                        mem_valid_i,
    // Ways
    cache_way_if.ctrl                        ways_o,
    input  wire logic                        hit_i,
    input  wire load_cache_pkg::data_word_t  hit_data_i
);

    // Enough LFSR bits to name one of the ways
    localparam int VICTIM_W = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_MEM_REQ,
        ST_REFILL,
        ST_DATA_READY
    } state_e;

    state_e state_q;

    load_cache_pkg::load_addr_u addr_q;
    load_cache_pkg::load_addr_u block_base;
    load_cache_pkg::data_word_t data_q;
    logic                       cachable_q;
    logic                       lookup_q;
    logic [load_cache_pkg::OFFSET_W-1:0] word_cnt_q;
    logic [WAYS-1:0]            fill_mask_q;
    logic [WAYS-1:0]            victim;
    logic [2:0]                 lfsr_q;

    logic take_req;
    logic hit_take;
    logic miss_active;
    logic refill_word;
    logic last_word;

    // ----------------------------------------------------------------------
    // Status decode
    // ----------------------------------------------------------------------

    // A new load may start in the cycle that returns the previous one
    assign idle_o      = (state_q == ST_IDLE) || (state_q == ST_DATA_READY);
    assign ld_valid_o  = (state_q == ST_DATA_READY);
    assign ld_data_o   = data_q;
    assign take_req    = ld_req_i && idle_o;

    // The lookup strobe is out during the first compare cycle, so the way
    // registers only hold the answer in the second one
    assign hit_take    = (state_q == ST_COMPARE) && !lookup_q && hit_i;

    assign miss_active = (state_q == ST_MEM_REQ) || (state_q == ST_REFILL);
    assign refill_word = (state_q == ST_REFILL) && mem_valid_i;
    assign last_word   = (word_cnt_q == load_cache_pkg::OFFSET_W'(
                             load_cache_pkg::BLOCK_WORDS - 1));

    // ----------------------------------------------------------------------
    // Memory interface
    // ----------------------------------------------------------------------

    always_comb begin
        block_base = addr_q;
        block_base.fields.offset = '0;
        block_base.fields.byte_off = '0;
    end

    // Request stays up as long as words are still owed to us
    assign mem_req_o  = miss_active;
    // A block refill starts at word zero, an uncached load asks for its word only
    assign mem_addr_o = cachable_q ? block_base.word : addr_q.word;

    // Drive the way array
    assign ways_o.lookup    = lookup_q;
    assign ways_o.index     = addr_q.fields.index;
    assign ways_o.offset    = (state_q == ST_REFILL) ? word_cnt_q : addr_q.fields.offset;
    assign ways_o.fill_mask = fill_mask_q;
    assign ways_o.fill_we   = refill_word;
    assign ways_o.fill_data = mem_data_i;
    assign ways_o.fill_tag  = addr_q.fields.tag;
    assign ways_o.fill_last = refill_word && last_word;

    // ----------------------------------------------------------------------
    // Random victim
    // ----------------------------------------------------------------------

    // Three-bit XNOR LFSR, held still while memory is busy
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lfsr_q <= 3'b010;
        end else if (!miss_active) begin
            lfsr_q <= {lfsr_q[1:0], ~(lfsr_q[2] ^ lfsr_q[1])};
        end
    end

    // Low LFSR bits turned into a one-hot way select
    assign victim = WAYS'(1) << lfsr_q[VICTIM_W-1:0];

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            lookup_q    <= 1'b0;
            word_cnt_q  <= '0;
            fill_mask_q <= '0;
        end else begin
            lookup_q <= 1'b0;
            case (state_q)
                ST_IDLE, ST_DATA_READY: begin
                    state_q <= ST_IDLE;
                    if (ld_req_i) begin
                        // A matching store wins over both the cache and memory
                        if (fwd_match_i) begin
                            state_q <= ST_DATA_READY;
                        end else if (ld_cachable_i) begin
                            state_q  <= ST_COMPARE;
                            lookup_q <= 1'b1;
                        end else begin
                            state_q <= ST_MEM_REQ;
                        end
                    end
                end
                ST_COMPARE: begin
                    if (!lookup_q) begin
                        if (hit_i) begin
                            state_q <= ST_DATA_READY;
                        end else begin
                            // Freeze the victim for the whole refill
                            state_q     <= ST_REFILL;
                            word_cnt_q  <= '0;
                            fill_mask_q <= victim;
                        end
                    end
                end
                ST_MEM_REQ: begin
                    if (mem_valid_i) begin
                        state_q <= ST_DATA_READY;
                    end
                end
                ST_REFILL: begin
                    // Words come back in ascending order, so a counter tracks them
                    if (mem_valid_i) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            state_q <= ST_DATA_READY;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Address and load data
    always_ff @(posedge clk_i) begin
        if (take_req) begin
            addr_q     <= ld_addr_i;
            cachable_q <= ld_cachable_i;
        end
        if (take_req && fwd_match_i) begin
            data_q <= fwd_data_i;
        end else if (hit_take) begin
            data_q <= hit_data_i;
        end else if ((state_q == ST_MEM_REQ) && mem_valid_i) begin
            data_q <= mem_data_i;
        end else if (refill_word && (word_cnt_q == addr_q.fields.offset)) begin
            // Grab the requested word as it streams past into the victim
            data_q <= mem_data_i;
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------

    // Each load returns once, the only back-to-back case is a forwarded
    // load accepted in the very cycle the previous one returned
    a_valid_strobe : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_valid_o && !(ld_req_i && fwd_match_i) |=> !ld_valid_o);

    // Memory is never asked for data while the controller claims to be idle
    a_req_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_req_o && idle_o));

endmodule

`default_nettype wire

// File: design/load_cache_pkg.sv
`default_nettype none

package load_cache_pkg;

    // ----------------------------------------------------------------------
    // Cache geometry
    // ----------------------------------------------------------------------

    // Data words and addresses share one width
    localparam int WORD_W = 32;

    // Four words per block, filled one word at a time from memory
    localparam int BLOCK_WORDS = 4;
    localparam int OFFSET_W = 2;

    // Sixteen sets in every way
    localparam int SETS = 16;
    localparam int INDEX_W = 4;

    // Whatever is left above index, offset and the two byte bits
    localparam int TAG_W = WORD_W - INDEX_W - OFFSET_W - 2;

    // ----------------------------------------------------------------------
    // Types
    // ----------------------------------------------------------------------

    typedef logic [WORD_W-1:0] data_word_t;

    // A load address is compared whole against the forwarded store and
    // sent as is to memory, but the lookup needs it split into fields
    typedef union packed {
        data_word_t word;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [INDEX_W-1:0]  index;
            logic [OFFSET_W-1:0] offset;
            // Byte lanes inside a word, never looked at by the cache
            logic [1:0]          byte_off;
        } fields;
    } load_addr_u;

endpackage

`default_nettype wire

// File: design/load_cache_top.sv
`default_nettype none

module load_cache_top #(
    parameter int WAYS = 4
) (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,
    // Load request and result
    input  wire logic                        ld_req_i,
    input  wire load_cache_pkg::load_addr_u  ld_addr_i,
    input  wire logic                        ld_cachable_i,
    output load_cache_pkg::data_word_t       ld_data_o,
    output logic                             ld_valid_o,
    output logic                             idle_o,
    // Store forwarding
    input  wire logic                        fwd_match_i,
    input  wire load_cache_pkg::data_word_t  fwd_data_i,
    // External memory
    output logic                             mem_req_o,
    output load_cache_pkg::data_word_t       mem_addr_o,
    input  wire load_cache_pkg::data_word_t  mem_data_i,
    input  wire logic                        mem_valid_i
);

    logic [WAYS-1:0]            way_hit;
    load_cache_pkg::data_word_t way_data [WAYS];
    logic                       hit;
    load_cache_pkg::data_word_t hit_data;

    // Command bus from the controller to every way
    cache_way_if #(.WAYS(WAYS)) ways_if ();

    load_cache_ctrl #(
        .WAYS(WAYS)
    ) u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ld_req_i      (ld_req_i),
        .ld_addr_i     (ld_addr_i),
        .ld_cachable_i (ld_cachable_i),
        .ld_data_o     (ld_data_o),
        .ld_valid_o    (ld_valid_o),
        .idle_o        (idle_o),
        .fwd_match_i   (fwd_match_i),
        .fwd_data_i    (fwd_data_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_i    (mem_data_i),
        .mem_valid_i   (mem_valid_i),
        .ways_o        (ways_if.ctrl),
        .hit_i         (hit),
        .hit_data_i    (hit_data)
    );

    // One identical way per position, WAY_ID picks its victim bit
    for (genvar g = 0; g < WAYS; g++) begin : g_way
        cache_way #(
            .WAYS   (WAYS),
            .WAY_ID (g)
        ) u_way (
            .clk_i      (clk_i),
            .rst_n_i    (rst_n_i),
            .ways_i     (ways_if.way),
            .way_hit_o  (way_hit[g]),
            .way_data_o (way_data[g])
        );
    end

    way_hit_select #(
        .WAYS(WAYS)
    ) u_hit_select (
        .way_hit_i  (way_hit),
        .way_data_i (way_data),
        .hit_o      (hit),
        .data_o     (hit_data)
    );

endmodule

`default_nettype wire

// File: design/way_hit_select.sv
`default_nettype none

module way_hit_select #(
    parameter int WAYS = 4
) (
    input  wire logic [WAYS-1:0]          way_hit_i,
    input  wire load_cache_pkg::data_word_t way_data_i [WAYS],
    output logic                          hit_o,
    output load_cache_pkg::data_word_t    data_o
);

    // Any way hitting is a hit
    assign hit_o = |way_hit_i;

    // AND-OR merge, which is safe as long as hits are exclusive
    always_comb begin
        data_o = '0;
        for (int i = 0; i < WAYS; i++) begin
            data_o = data_o | (way_data_i[i] & {load_cache_pkg::WORD_W{way_hit_i[i]}});
        end
    end

    // A block lives in one way only, so two hits mean a refill went wrong
    // upstream
    always_comb begin
        a_one_hit : assert final ($isunknown(way_hit_i) || $onehot0(way_hit_i));
    end

endmodule

`default_nettype wire

// File: load_cache.f
design/load_cache_pkg.sv
design/cache_way_if.sv
design/load_cache_ctrl.sv
design/cache_way.sv
design/way_hit_select.sv
design/load_cache_top.sv
tb/load_cache_tb.sv

// File: tb/load_cache_tb.sv
`default_nettype none

module load_cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    // Memory contents are the address with a fixed pattern folded in
    localparam logic [31:0] MEM_KEY     = 32'h5a3c_96e1;
    localparam int          BLOCK_BYTES = load_cache_pkg::BLOCK_WORDS * 4;
    localparam int          WAIT_LIMIT  = 200;
    localparam int          GAPS        = 64;

    logic                       clk_i;
    logic                       rst_n_i;
    logic                       ld_req_i;
    load_cache_pkg::load_addr_u ld_addr_i;
    logic                       ld_cachable_i;
    load_cache_pkg::data_word_t ld_data_o;
    logic                       ld_valid_o;
    logic                       idle_o;
    logic                       fwd_match_i;
    load_cache_pkg::data_word_t fwd_data_i;
    logic                       mem_req_o;
    load_cache_pkg::data_word_t mem_addr_o;
    load_cache_pkg::data_word_t mem_data_i;
    logic                       mem_valid_i;

    // Expectations for the load in flight, set when it is issued
    load_cache_pkg::data_word_t exp_data;
    load_cache_pkg::data_word_t exp_mem_addr;
    int                         exp_words;
    logic                       count_known;
    logic                       expect_hit;

    int          words_cnt;
    int          assert_errors;
    int          timeout_errors;
    logic        timed_out;
    int unsigned gap_tab [GAPS];
    int          gap_ptr;

    load_cache_top #(
        .WAYS(4)
    ) dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .ld_req_i      (ld_req_i),
        .ld_addr_i     (ld_addr_i),
        .ld_cachable_i (ld_cachable_i),
        .ld_data_o     (ld_data_o),
        .ld_valid_o    (ld_valid_o),
        .idle_o        (idle_o),
        .fwd_match_i   (fwd_match_i),
        .fwd_data_i    (fwd_data_i),
        .mem_req_o     (mem_req_o),
        .mem_addr_o    (mem_addr_o),
        .mem_data_i    (mem_data_i),
        .mem_valid_i   (mem_valid_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic load_cache_pkg::data_word_t model_word(input logic [31:0] addr);
        return addr ^ MEM_KEY;
    endfunction

    // ----------------------------------------------------------------------
    // Memory model and word counter
    // ----------------------------------------------------------------------

    // Words go out in ascending order while the request is up, each one
    // after a random gap taken from a table filled at the start of the run
    initial begin
        int idx;
        mem_valid_i = 1'b0;
        mem_data_i  = '0;
        gap_ptr     = 0;
        forever begin
            @(negedge clk_i);
            if (rst_n_i && mem_req_o) begin
                idx = 0;
                while (mem_req_o && idx < load_cache_pkg::BLOCK_WORDS) begin
                    repeat (gap_tab[gap_ptr % GAPS]) @(negedge clk_i);
                    gap_ptr++;
                    mem_data_i  = model_word(mem_addr_o + 32'(idx * 4));
                    mem_valid_i = 1'b1;
                    @(negedge clk_i);
                    mem_valid_i = 1'b0;
                    idx++;
                end
            end
        end
    end

    // Memory words delivered since the last accepted load
    always @(posedge clk_i) begin
        if (ld_req_i && idle_o) begin
            words_cnt <= 0;
        end else if (mem_valid_i) begin
            words_cnt <= words_cnt + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Assertions
    // ----------------------------------------------------------------------

    a_reset_state : assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> idle_o && !ld_valid_o && !mem_req_o)
        else begin
            assert_errors++;
            $display("Outputs are not in their reset state when reset is released");
        end

    a_load_data : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_valid_o |-> ld_data_o == exp_data)
        else begin
            assert_errors++;
            $display("Error at %0t: ld_data_o is %h, expected %h",
                     $time, $sampled(ld_data_o), $sampled(exp_data));
        end

    // Forwarded data comes back in the very next cycle without memory
    a_fwd_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_req_i && idle_o && fwd_match_i |=> ld_valid_o && !mem_req_o)
        else begin
            assert_errors++;
            $display("Forwarded load did not return one cycle after its request");
        end

    // The ways register the lookup one edge after the request and the
    // controller registers their word on the edge after that
    a_hit_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_req_i && idle_o && expect_hit |=>
            !ld_valid_o && !mem_req_o ##1 !ld_valid_o && !mem_req_o
            ##1 ld_valid_o && !mem_req_o)
        else begin
            assert_errors++;
            $display("Cache hit did not return two cycles after its request");
        end

    a_mem_addr : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(mem_req_o) |-> mem_addr_o == exp_mem_addr)
        else begin
            assert_errors++;
            $display("Error at %0t: mem_addr_o is %h, expected %h",
                     $time, $sampled(mem_addr_o), $sampled(exp_mem_addr));
        end

    a_mem_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o))
        else begin
            assert_errors++;
            $display("Memory address changed while the request was held");
        end

    a_word_count : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_valid_o && count_known |-> words_cnt == exp_words)
        else begin
            assert_errors++;
            $display("Error at %0t: words_cnt is %0d, expected %0d",
                     $time, $sampled(words_cnt), $sampled(exp_words));
        end

    // Random cachable loads either hit or pull one full block
    a_block_count : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ld_valid_o && !count_known |->
            words_cnt == 0 || words_cnt == load_cache_pkg::BLOCK_WORDS)
        else begin
            assert_errors++;
            $display("A cachable load took a partial block from memory");
        end

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!idle_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!idle_o) begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("Timed out at %0t waiting for the controller to go idle", $time);
        end
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (!ld_valid_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (!ld_valid_o) begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("Timed out at %0t waiting for load data", $time);
        end
    endtask

    // Words is the memory word count the load must take, or -1 if unknown
    task automatic do_load(input logic [31:0] addr, input logic cach, input logic fwd,
                           input logic [31:0] fdata, input logic hit, input int words);
        if (timed_out) begin
            return;
        end
        wait_idle();
        if (timed_out) begin
            return;
        end
        exp_data      = fwd ? fdata : model_word(addr);
        exp_mem_addr  = cach ? (addr & ~32'(BLOCK_BYTES - 1)) : addr;
        exp_words     = words;
        count_known   = (words >= 0);
        expect_hit    = hit;
        ld_req_i      = 1'b1;
        ld_addr_i     = addr;
        ld_cachable_i = cach;
        fwd_match_i   = fwd;
        fwd_data_i    = fdata;
        @(negedge clk_i);
        ld_req_i    = 1'b0;
        fwd_match_i = 1'b0;
        expect_hit  = 1'b0;
        wait_valid();
        // One more edge so the result is sampled before expectations move on
        @(negedge clk_i);
    endtask

    initial begin
        logic [31:0] addr;
        logic        cach;
        logic        fwd;
        void'($urandom(32'h9ba0));
        for (int i = 0; i < GAPS; i++) begin
            gap_tab[i] = $urandom_range(3);
        end
        rst_n_i        = 1'b0;
        ld_req_i       = 1'b0;
        ld_addr_i      = '0;
        ld_cachable_i  = 1'b0;
        fwd_match_i    = 1'b0;
        fwd_data_i     = '0;
        exp_data       = '0;
        exp_mem_addr   = '0;
        exp_words      = 0;
        count_known    = 1'b0;
        expect_hit     = 1'b0;
        assert_errors  = 0;
        timeout_errors = 0;
        timed_out      = 1'b0;
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk_i);

        // Forwarded store, then a block miss and a hit in the same block
        do_load(32'h0000_1230, 1'b1, 1'b1, 32'hcafe_0001, 1'b0, 0);
        do_load(32'h0000_2454, 1'b1, 1'b0, 32'h0, 1'b0, load_cache_pkg::BLOCK_WORDS);
        do_load(32'h0000_245c, 1'b1, 1'b0, 32'h0, 1'b1, 0);

        // Uncached loads allocate nothing, so the repeat goes to memory again
        do_load(32'h0000_3308, 1'b0, 1'b0, 32'h0, 1'b0, 1);
        do_load(32'h0000_3308, 1'b0, 1'b0, 32'h0, 1'b0, 1);

        // Random loads over three sets with more tags than ways
        for (int n = 0; n < 60 && !timed_out; n++) begin
            addr = '0;
            addr[31:8] = 24'($urandom_range(5) + 1);
            addr[7:4]  = 4'($urandom_range(2));
            addr[3:2]  = 2'($urandom_range(3));
            fwd  = ($urandom_range(7) == 0);
            cach = ($urandom_range(4) != 0);
            if (fwd) begin
                do_load(addr, cach, 1'b1, $urandom, 1'b0, 0);
            end else if (!cach) begin
                do_load(addr, 1'b0, 1'b0, 32'h0, 1'b0, 1);
            end else begin
                do_load(addr, 1'b1, 1'b0, 32'h0, 1'b0, -1);
            end
        end
        repeat (4) @(negedge clk_i);

        $display("Checks finished with %0d assertion errors and %0d timeouts",
                 assert_errors, timeout_errors);
        if (assert_errors == 0 && timeout_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
